//--- Makefile
# Verilator build and run of the icache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= icache.f
BUILD     ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: check

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	$(BIN) | tee $(LOG)

check: run
	@grep -qF '$(PASS_TEXT)' $(LOG) && echo "simulation passed" || \
	  (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

//--- icache.f
+incdir+source
source/icache_pkg.sv
source/way_bus.sv
source/cache_ctrl.sv
source/way_bank.sv
source/way_select.sv
source/icache.sv
verification/tb_icache.sv

//--- source/cache_ctrl.sv
/*
  icache controller
  idle / lookup / fill fsm, request address register,
  ram read address steering and the age / fill write strobes
*/
`default_nettype none

`include "icache_consts.svh"

module cache_ctrl (
  input  wire logic              CLK,
  input  wire logic              resetn,
  input  wire logic              read_en,
  input  wire icache_pkg::addr_t read_addr,
  input  wire logic              fetch,
  output logic                   cache_miss,
  output logic                   fetch_valid,
  way_bus.ctrl                   bus
);
  import icache_pkg::*;

  localparam int IDX_LSB = `ICACHE_OFFSET_BITS;
  localparam int TAG_LSB = `ICACHE_OFFSET_BITS + `ICACHE_INDEX_BITS;

  typedef enum logic [1:0] {
    IDLE,
    LOOKUP,
    FILL
  } state_t;

  state_t state, state_next;
  addr_t  addr_q;           // last issued request
  index_t new_index;
  index_t held_index;
  tag_t   held_tag;
  logic   issue;            // read accepted at this edge

  assign new_index  = read_addr[IDX_LSB +: `ICACHE_INDEX_BITS];
  assign held_index = addr_q[IDX_LSB +: `ICACHE_INDEX_BITS];
  assign held_tag   = addr_q[TAG_LSB +: `ICACHE_TAG_BITS];

  // a new read goes in from idle or behind a hit
  assign issue = read_en && ((state == IDLE) || (state == LOOKUP && bus.lookup_hit));

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (read_en) state_next = LOOKUP;
      end
      LOOKUP: begin
        if (!bus.lookup_hit) state_next = FILL;       // miss, wait for memory
        else if (read_en)    state_next = LOOKUP;     // back to back hits
        else                 state_next = IDLE;
      end
      FILL: begin
        if (fetch) state_next = IDLE;   // requester re-issues, then it hits
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // payload only, loaded on issue
  always_ff @(posedge CLK) begin
    if (issue) addr_q <= read_addr;
  end

  // ram read address for the coming cycle
  // fill keeps rereading the held row so tags and ages stay on the bus
  always_comb begin
    if (state_next == FILL) bus.rd_index = held_index;
    else                    bus.rd_index = new_index;
  end

  assign bus.wr_index   = held_index;
  assign bus.lookup_tag = held_tag;

  // status towards the fetch unit and memory
  assign fetch_valid = (state == LOOKUP) && bus.lookup_hit;
  assign cache_miss  = ((state == LOOKUP) && !bus.lookup_hit) ||
                       ((state == FILL) && !fetch);   // drops in the fetch cycle

  // write strobes, taken at the closing edge
  assign bus.fill   = (state == FILL) && fetch;
  assign bus.update = fetch_valid || bus.fill;   // hit and fill age alike

endmodule

`default_nettype wire

//--- source/icache.sv
/*
  4-way instruction cache, 256 sets of one 32-bit instruction
  one cycle hit latency, refill from external memory on a miss
*/
`default_nettype none

`include "icache_consts.svh"

module icache (
  input  wire logic              CLK,
  input  wire logic              resetn,
  input  wire logic              read_en,
  input  wire icache_pkg::addr_t read_addr,
  input  wire logic              fetch,        // memory strobe, line on write_data
  input  wire icache_pkg::word_t write_data,
  output logic                   cache_miss,
  output logic                   fetch_valid,
  output icache_pkg::word_t      read_data
);

  way_bus bus ();

  cache_ctrl u_ctrl (
    .CLK         (CLK),
    .resetn      (resetn),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fetch       (fetch),
    .cache_miss  (cache_miss),
    .fetch_valid (fetch_valid),
    .bus         (bus)
  );

  // one bank per way, the loop index is the way number
  for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
    way_bank #(
      .WAY_ID (w)
    ) u_bank (
      .CLK        (CLK),
      .resetn     (resetn),
      .write_data (write_data),
      .bus        (bus)
    );
  end

  way_select u_sel (
    .bus (bus)
  );

  assign read_data = bus.read_data;   // valid with fetch_valid

endmodule

`default_nettype wire

//--- source/icache_consts.svh
/*
  icache sizing constants
  way count, set count and address / word field widths
*/
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// organisation
`define ICACHE_WAYS 4           // 4-way set associative
`define ICACHE_SETS 256         // one instruction per line

// request address split
`define ICACHE_OFFSET_BITS 2    // byte offset, ignored
`define ICACHE_INDEX_BITS 8     // addr[9:2]
`define ICACHE_TAG_BITS 10      // addr[19:10]
`define ICACHE_ADDR_BITS 20     // 1MB of instruction space

// payload and replacement state
`define ICACHE_WORD_BITS 32
`define ICACHE_AGE_BITS 2       // enough to order 4 ways

`endif

//--- source/icache_pkg.sv
/*
  icache package
  named width types shared by the controller, the way banks and the selector
*/
`default_nettype none

`include "icache_consts.svh"

package icache_pkg;

  // request byte address from the fetch unit
  typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

  // set index, picks one row in every way
  typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

  // stored tag, upper address bits
  typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;

  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;  // one instruction

  // lru age, 0 = most recently used
  typedef logic [`ICACHE_AGE_BITS-1:0] age_t;

  // way number, same width as the age since there are 4 ways
  typedef logic [$clog2(`ICACHE_WAYS)-1:0] way_t;

endpackage

`default_nettype wire

//--- source/way_bank.sv
/*
  one icache way
  tag+age ram, data ram and valid flops for all sets,
  tag compare and lru age rewrite
*/
`default_nettype none

`include "icache_consts.svh"

module way_bank #(
  parameter int WAY_ID = 0
) (
  input  wire logic              CLK,
  input  wire logic              resetn,
  input  wire icache_pkg::word_t write_data,
  way_bus.bank                   bus
);
  import icache_pkg::*;

  localparam way_t SELF       = way_t'(WAY_ID);
  localparam int   ENTRY_BITS = `ICACHE_TAG_BITS + `ICACHE_AGE_BITS;

  // storage
  logic [ENTRY_BITS-1:0] tag_age_mem [`ICACHE_SETS];   // {tag, age}
  word_t                 data_mem    [`ICACHE_SETS];
  logic [`ICACHE_SETS-1:0] valid_bits;                  // cleared by reset

  // read side
  logic [ENTRY_BITS-1:0] entry_q;
  tag_t  tag_q;
  age_t  age_q;
  word_t data_q;
  logic  valid_q;

  // write side
  logic [ENTRY_BITS-1:0] entry_new;
  age_t  age_now;
  age_t  age_new;
  logic  own_fill;
  logic  entry_we;

  assign {tag_q, age_q} = entry_q;

  // ram contents of an empty way are undefined, so it reports oldest
  assign age_now = valid_q ? age_q : '1;

  assign own_fill = bus.fill && (bus.used_way == SELF);
  assign entry_we = bus.update;   // every way rewrites its age

  // used way goes to 0, younger ways age by one
  always_comb begin
    if (bus.used_way == SELF)          age_new = '0;
    else if (age_now < bus.used_age)   age_new = age_now + 1'b1;
    else                               age_new = age_now;
  end

  // tag only changes on our own fill
  assign entry_new = {(own_fill ? bus.lookup_tag : tag_q), age_new};

  always_ff @(posedge CLK) begin
    if (entry_we) tag_age_mem[bus.wr_index] <= entry_new;
  end

  // write-first read, back to back hits on one row see the new ages
  always_ff @(posedge CLK) begin
    if (entry_we && (bus.wr_index == bus.rd_index)) entry_q <= entry_new;
    else                                            entry_q <= tag_age_mem[bus.rd_index];
  end

  always_ff @(posedge CLK) begin
    if (own_fill) data_mem[bus.wr_index] <= write_data;
  end

  always_ff @(posedge CLK) begin
    data_q <= data_mem[bus.rd_index];   // 1 cycle read
  end

  always_ff @(posedge CLK) begin
    if (!resetn) begin
      valid_bits <= '0;
      valid_q    <= 1'b0;
    end else begin
      if (own_fill) valid_bits[bus.wr_index] <= 1'b1;
      valid_q <= valid_bits[bus.rd_index];   // same timing as the rams
    end
  end

  // per-way results
  assign bus.hit[WAY_ID]   = valid_q && (tag_q == bus.lookup_tag);
  assign bus.valid[WAY_ID] = valid_q;
  assign bus.age[WAY_ID]   = age_now;
  assign bus.rdata[WAY_ID] = data_q;

endmodule

`default_nettype wire

//--- source/way_bus.sv
/*
  way bus
  joins the controller, the per-way banks and the way selector
*/
`default_nettype none

`include "icache_consts.svh"

interface way_bus;
  import icache_pkg::*;

  // from the controller
  index_t rd_index;      // ram read address, sampled at the issue edge
  index_t wr_index;      // held request index
  tag_t   lookup_tag;    // held request tag
  logic   update;        // rewrite ages this cycle
  logic   fill;          // write tag, valid and data into used_way

  // from the selector
  way_t   used_way;      // hit way in lookup, victim otherwise
  age_t   used_age;
  logic   lookup_hit;
  word_t  read_data;

  // one slot per bank
  logic   hit   [`ICACHE_WAYS];
  logic   valid [`ICACHE_WAYS];
  age_t   age   [`ICACHE_WAYS];
  word_t  rdata [`ICACHE_WAYS];

  modport ctrl (
    output rd_index, wr_index, lookup_tag, update, fill,
    input  lookup_hit
  );

  modport bank (
    input  rd_index, wr_index, lookup_tag, update, fill, used_way, used_age,
    output hit, valid, age, rdata
  );

  modport sel (
    input  hit, valid, age, rdata,
    output lookup_hit, used_way, used_age, read_data
  );

endinterface

`default_nettype wire

//--- source/way_select.sv
/*
  way selector
  merges the per-way hits, muxes the hit data and picks the victim way
*/
`default_nettype none

`include "icache_consts.svh"

module way_select (
  way_bus.sel bus
);
  import icache_pkg::*;

  logic any_hit;
  logic any_free;
  way_t hit_way;      // lowest hitting way
  way_t free_way;     // lowest invalid way
  way_t oldest_way;   // highest age, lowest way on a tie
  age_t oldest_age;
  way_t victim;

  // descending scan so the lowest hit is taken last
  always_comb begin
    any_hit = 1'b0;
    hit_way = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (bus.hit[i]) begin
        any_hit = 1'b1;
        hit_way = way_t'(i);
      end
    end
  end

  always_comb begin
    any_free = 1'b0;
    free_way = '0;
    for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
      if (!bus.valid[i]) begin
        any_free = 1'b1;
        free_way = way_t'(i);
      end
    end
  end

  // strict compare keeps the lower way on equal ages
  always_comb begin
    oldest_way = '0;
    oldest_age = bus.age[0];
    for (int i = 1; i < `ICACHE_WAYS; i++) begin
      if (bus.age[i] > oldest_age) begin
        oldest_way = way_t'(i);
        oldest_age = bus.age[i];
      end
    end
  end

  assign victim = any_free ? free_way : oldest_way;   // fill empty ways first

  // no way hits during fill, so the victim is used there
  assign bus.lookup_hit = any_hit;
  assign bus.used_way   = any_hit ? hit_way : victim;
  assign bus.used_age   = bus.age[bus.used_way];
  assign bus.read_data  = bus.rdata[hit_way];   // only meaningful with a hit

endmodule

`default_nettype wire

//--- verification/tb_icache.sv
/*
  icache testbench
  checks reads against a tag, valid and age reference model
  and answers misses like the external memory
*/
`default_nettype none

`include "icache_consts.svh"

module tb_icache;
  import icache_pkg::*;

  localparam int     WAIT_LIMIT = 20;       // cycles before a wait gives up
  localparam index_t IDX_FOUR   = 8'h33;    // four ways resident
  localparam index_t IDX_LRU    = 8'h5a;    // eviction order

  logic  CLK;
  logic  resetn;
  logic  read_en;
  addr_t read_addr;
  logic  fetch;
  word_t write_data;
  logic  cache_miss;
  logic  fetch_valid;
  word_t read_data;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     errors_at_start;
  string  test_name;
  addr_t  resident [$];   // lines the model holds for streaming

  // reference model where an empty way counts as oldest
  logic m_valid [`ICACHE_WAYS][`ICACHE_SETS];
  tag_t m_tag   [`ICACHE_WAYS][`ICACHE_SETS];
  age_t m_age   [`ICACHE_WAYS][`ICACHE_SETS];

  icache dut (
    .CLK         (CLK),
    .resetn      (resetn),
    .read_en     (read_en),
    .read_addr   (read_addr),
    .fetch       (fetch),
    .write_data  (write_data),
    .cache_miss  (cache_miss),
    .fetch_valid (fetch_valid),
    .read_data   (read_data)
  );

  always #50 CLK = ~CLK;   // period 100

  function automatic tag_t tag_of(input addr_t a);
    return a[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  endfunction

  function automatic index_t index_of(input addr_t a);
    return a[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
  endfunction

  function automatic addr_t make_addr(input tag_t t, input index_t i);
    return {t, i, {`ICACHE_OFFSET_BITS{1'b0}}};
  endfunction

  // memory contents use an odd multiplier so every line address gets its own word
  function automatic word_t line_hash(input addr_t a);
    logic [`ICACHE_ADDR_BITS-`ICACHE_OFFSET_BITS-1:0] line;
    line = a[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];
    return ({line[13:0], line} * 32'h9e37_79b1) ^ 32'h5bd1_e995;
  endfunction

  function automatic void model_clear();
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      for (int s = 0; s < `ICACHE_SETS; s++) begin
        m_valid[w][s] = 1'b0;
        m_tag[w][s]   = '0;
        m_age[w][s]   = '1;
      end
    end
  endfunction

  // lowest matching way or -1 on a miss
  function automatic int model_find(input addr_t a);
    int found;
    found = -1;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (m_valid[w][index_of(a)] && m_tag[w][index_of(a)] == tag_of(a)) found = w;
    end
    return found;
  endfunction

  // first empty way else the oldest with the lower way winning a tie
  function automatic int model_victim(input index_t idx);
    int v;
    v = -1;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--) begin
      if (!m_valid[w][idx]) v = w;
    end
    if (v < 0) begin
      v = 0;
      for (int w = 1; w < `ICACHE_WAYS; w++) begin
        if (m_age[w][idx] > m_age[v][idx]) v = w;
      end
    end
    return v;
  endfunction

  // used way goes to 0 and every way younger than it ages by one
  function automatic void model_use(input index_t idx, input int way);
    age_t used;
    used = m_age[way][idx];
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (w == way) m_age[w][idx] = '0;
      else if (m_age[w][idx] < used) m_age[w][idx] = age_t'(m_age[w][idx] + 1);
    end
  endfunction

  function automatic void model_fill(input addr_t a);
    int v;
    v = model_victim(index_of(a));
    model_use(index_of(a), v);   // ages first while the empty way still reads oldest
    m_valid[v][index_of(a)] = 1'b1;
    m_tag[v][index_of(a)]   = tag_of(a);
  endfunction

  function automatic addr_t pick_resident();
    addr_t a;
    a = resident[$unsigned($random(seed)) % resident.size()];
    return a | addr_t'($unsigned($random(seed)) % 4);   // offset bits are ignored
  endfunction

  task automatic check_that(input logic ok, input string what);
    assert (ok) else begin
      $display("CHECK FAILED at %0t: %s", $time, what);
      errors++;
    end
  endtask

  // memory side strobes fetch 1 to 4 cycles after cache_miss rose
  task automatic serve_miss(input addr_t a);
    int delay;
    delay = 1 + int'($unsigned($random(seed)) % 4);
    repeat (delay - 1) begin
      @(posedge CLK);
      @(negedge CLK);
      check_that(cache_miss && !fetch_valid, $sformatf("miss on %h not held during fill", a));
    end
    @(posedge CLK);
    fetch      <= 1'b1;
    write_data <= line_hash(a);
    @(negedge CLK);
    check_that(!cache_miss && !fetch_valid, "cache_miss or fetch_valid high in fetch cycle");
    @(posedge CLK);   // fill lands here
    fetch      <= 1'b0;
    write_data <= $random(seed);   // junk between strobes
  endtask

  // one read from idle with the result checked against the model
  task automatic read_line(input addr_t a, output logic hit);
    int waited;
    int exp_way;
    exp_way = model_find(a);
    hit     = 1'b0;
    @(posedge CLK);
    read_en   <= 1'b1;
    read_addr <= a;
    @(posedge CLK);   // issue edge
    read_en <= 1'b0;
    waited  = 0;
    @(negedge CLK);
    while (!fetch_valid && !cache_miss && waited < WAIT_LIMIT) begin
      @(negedge CLK);
      waited++;
    end
    if (!fetch_valid && !cache_miss) begin
      $display("timeout: no hit or miss within %0d cycles of reading %h", WAIT_LIMIT, a);
      errors++;
    end else begin
      check_that(waited == 0, $sformatf("result for %h came %0d cycles late", a, waited));
      check_that(!(fetch_valid && cache_miss), "fetch_valid and cache_miss both high");
      hit = fetch_valid;
      check_that(hit == (exp_way >= 0),
                 $sformatf("%h gave hit=%0b, model expects %0b", a, hit, exp_way >= 0));
      if (hit) begin
        check_that(read_data == line_hash(a),
                   $sformatf("%h read %h, expected %h", a, read_data, line_hash(a)));
        if (exp_way >= 0) model_use(index_of(a), exp_way);
      end else begin
        serve_miss(a);
        if (exp_way < 0) model_fill(a);
      end
    end
  endtask

  // read_en held with one new resident address per lookup cycle
  task automatic stream_hits(input int count);
    addr_t cur;
    addr_t nxt;
    int    way;
    cur = pick_resident();
    @(posedge CLK);
    read_en   <= 1'b1;
    read_addr <= cur;
    @(posedge CLK);   // first issue
    for (int k = 0; k < count; k++) begin
      nxt = pick_resident();
      if (k == count - 1) read_en <= 1'b0;
      else read_addr <= nxt;   // taken behind this hit
      @(negedge CLK);
      way = model_find(cur);
      check_that(fetch_valid, $sformatf("no hit for resident %h while streaming", cur));
      check_that(!cache_miss, "cache_miss high while streaming");
      check_that(read_data == line_hash(cur),
                 $sformatf("stream read of %h gave %h", cur, read_data));
      if (way >= 0) model_use(index_of(cur), way);
      cur = nxt;
      @(posedge CLK);
    end
  endtask

  // a new tag evicts the oldest line, then every old line is read again
  task automatic evict_and_recheck(input index_t idx);
    addr_t old_lines [$];
    logic  hit;
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[w][idx]) old_lines.push_back(make_addr(m_tag[w][idx], idx));
    end
    read_line(make_addr(tag_t'(10'h3ff), idx), hit);
    foreach (old_lines[i]) read_line(old_lines[i], hit);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: pass", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, test_name, errors - errors_at_start);
    end
  endtask

  task automatic test_lru();
    tag_t tags [5];
    logic hit;
    tags = '{10'h0a1, 10'h0b2, 10'h0c3, 10'h0d4, 10'h0e5};   // A B C D E
    start_test("lru eviction");
    for (int i = 0; i < 4; i++) read_line(make_addr(tags[i], IDX_LRU), hit);
    read_line(make_addr(tags[0], IDX_LRU), hit);   // A becomes youngest
    check_that(hit, "re-read of A did not hit");
    read_line(make_addr(tags[4], IDX_LRU), hit);
    check_that(!hit, "fifth tag E did not miss");
    foreach (tags[i]) begin
      if (i != 1) begin
        read_line(make_addr(tags[i], IDX_LRU), hit);
        check_that(hit, $sformatf("tag %h lost after E filled", tags[i]));
      end
    end
    read_line(make_addr(tags[1], IDX_LRU), hit);   // B was the victim
    check_that(!hit, "B still resident after E filled");
    end_test();
  endtask

  task automatic test_mixed();
    index_t idx_pool [4];
    addr_t  a;
    logic   hit;
    idx_pool = '{8'h00, 8'h01, 8'h80, 8'hff};
    start_test("index independence");
    for (int n = 0; n < 80; n++) begin
      a = make_addr(tag_t'(10'h200 + $unsigned($random(seed)) % 6),
                    idx_pool[$unsigned($random(seed)) % 4]);
      read_line(a, hit);
      if (!hit) begin
        read_line(a, hit);   // requester re-issues after the fill
        check_that(hit, $sformatf("re-issue of %h after fill missed", a));
      end
    end
    end_test();
  endtask

  initial begin
    logic hit;
    seed            = 57;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    errors_at_start = 0;
    test_name       = "";
    CLK             = 1'b0;
    resetn          = 1'b0;
    read_en         = 1'b0;
    read_addr       = '0;
    fetch           = 1'b0;
    write_data      = '0;
    model_clear();
    repeat (3) @(posedge CLK);
    resetn <= 1'b1;

    start_test("reset and cold miss");
    @(negedge CLK);
    check_that(!cache_miss && !fetch_valid, "cache_miss or fetch_valid high after reset");
    read_line(make_addr(10'h3a5, 8'h12), hit);
    check_that(!hit, "first read after reset did not miss");
    end_test();

    start_test("fill then hit");
    read_line(make_addr(10'h155, 8'hc4), hit);
    read_line(make_addr(10'h155, 8'hc4), hit);
    check_that(hit, "re-read after fill missed");
    read_line(make_addr(10'h155, 8'hc4) | addr_t'(3), hit);   // other byte, same line
    check_that(hit, "same line at another offset missed");
    end_test();

    start_test("four ways resident");
    for (int i = 0; i < 4; i++) read_line(make_addr(tag_t'(10'h101 + i), IDX_FOUR), hit);
    for (int i = 0; i < 4; i++) begin
      read_line(make_addr(tag_t'(10'h101 + i), IDX_FOUR), hit);
      check_that(hit, $sformatf("way holding tag %h at set %h missed", 10'h101 + i, IDX_FOUR));
    end
    end_test();

    test_lru();

    start_test("streaming hits");
    resident.delete();
    for (int w = 0; w < `ICACHE_WAYS; w++) begin
      if (m_valid[w][IDX_FOUR]) resident.push_back(make_addr(m_tag[w][IDX_FOUR], IDX_FOUR));
      if (m_valid[w][IDX_LRU]) resident.push_back(make_addr(m_tag[w][IDX_LRU], IDX_LRU));
    end
    if (resident.size() == 0) begin
      $display("no resident lines left to stream over");
      errors++;
    end else begin
      stream_hits(40);
      evict_and_recheck(IDX_FOUR);   // ages left by the stream pick the victims
      evict_and_recheck(IDX_LRU);
    end
    end_test();

    test_mixed();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
